// File: build.f
logic/node_record_pkg.sv
logic/node_search_pkg.sv
logic/node_table_mem.sv
logic/scan_address_counter.sv
logic/node_search_fsm.sv
logic/child_slot_bank.sv
logic/node_search_top.sv
verification/node_search_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the node search testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module node_search_tb -f build.f
sim_output=$(./obj_dir/Vnode_search_tb) || true
echo "$sim_output"
if grep -qx "sim passed" <<< "$sim_output"; then
	exit 0
fi
exit 1

// File: verification/node_search_tb.sv
module node_search_tb;

	import node_record_pkg::*;
	import node_search_pkg::*;

	// ========================================
	// Run limits
	// ========================================

	localparam int MAX_NODES = 100;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;                // Inputs move just after the rising edge.
	localparam int SEARCH_COUNT = 9;               // Searches over all tests.
	localparam int SEARCH_CYCLES = 7 * MAX_NODES;  // Two full scans, three cycles an entry.
	localparam int LOAD_CYCLES = 16 * MAX_NODES;   // Table clears and node writes.
	localparam int WATCHDOG_CYCLES = SEARCH_COUNT * SEARCH_CYCLES + LOAD_CYCLES + 100;

	// Removed-node record, x 0, y 0, id, parent and cost 800.
	localparam node_record_t SENTINEL = {16'd0, 16'd0, 16'd800, 16'd800, 16'd800, 192'd0};

	typedef node_id_t [CHILD_SLOTS-1:0] id_list_t; // Child ids, slot 0 in the low field.

	logic clk;
	logic reset;
	logic find_node;
	node_id_t target_id;
	logic write_enable;
	node_addr_t write_address;
	node_record_t write_data;
	node_record_t node_record;
	node_record_t [CHILD_SLOTS-1:0] child_records;
	logic found;
	logic done;

	node_record_t model_table [MAX_NODES]; // Copy of the table.
	node_id_t model_id [MAX_NODES];
	id_list_t model_kids [MAX_NODES];
	node_record_t exp_node;
	node_record_t [CHILD_SLOTS-1:0] exp_children;
	logic exp_found;

	int errors;
	int test_errors;
	int tests_run;
	int checks;
	logic [31:0] rng_state;
	string test_name;

	node_search_top #(
		.MAX_NODES(MAX_NODES)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.find_node(find_node),
		.target_id(target_id),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.node_record(node_record),
		.child_records(child_records),
		.found(found),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13); // Xorshift32.
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int random_below(input int limit);
		return int'(next_random() % 32'(limit));
	endfunction

	// Field 0 on top, child id and distance pairs at the bottom.
	function automatic node_record_t make_record(input coord_t x, input node_id_t id,
			input id_list_t kids, input field_t extra);
		node_record_t rec;
		rec = {x, extra ^ 16'h0f0f, id, extra, extra ^ 16'h5a5a, 192'd0};
		for (int s = 0; s < CHILD_SLOTS; s++) begin
			rec[191 - 32 * s -: 16] = kids[s];
			rec[175 - 32 * s -: 16] = cost_t'(extra + 16'(s) + 16'd1); // Distance.
		end
		return rec;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic write_entry(input int addr, input node_record_t rec);
		write_enable = 1'b1;
		write_address = node_addr_t'(addr);
		write_data = rec;
		next_cycle();
		write_enable = 1'b0;
	endtask

	task automatic place_node(input int addr, input node_id_t id, input id_list_t kids,
			input field_t extra);
		node_record_t rec;
		rec = make_record(coord_t'(addr * 3), id, kids, extra);
		model_table[addr] = rec;
		model_id[addr] = id;
		model_kids[addr] = kids;
		write_entry(addr, rec);
	endtask

	task automatic clear_table();
		for (int i = 0; i < MAX_NODES; i++) begin
			model_table[i] = '0;
			model_id[i] = '0;
			model_kids[i] = '0;
			write_entry(i, '0); // Empty entry, id 0.
		end
	endtask

	// Strobe one request, then wait for the completion pulse.
	task automatic run_search(input node_id_t target);
		find_node = 1'b1;
		target_id = target;
		next_cycle();
		find_node = 1'b0;
		while (!done) begin
			next_cycle();
		end
	endtask

	// Node scan takes the first id hit. Child scan fills the lowest matching slot.
	function automatic void compute_expected(input node_id_t target);
		id_list_t node_kids;
		int count;
		int slot;
		exp_found = 1'b0;
		exp_node = SENTINEL;
		node_kids = '0;
		for (int i = 0; i < MAX_NODES; i++) begin
			if (!exp_found && model_id[i] == target) begin
				exp_found = 1'b1;
				exp_node = model_table[i];
				node_kids = model_kids[i];
			end
		end
		for (int s = 0; s < CHILD_SLOTS; s++) begin
			exp_children[s] = SENTINEL;
		end
		count = 0;
		for (int i = 0; i < MAX_NODES && count < CHILD_SLOTS; i++) begin
			slot = -1;
			for (int s = CHILD_SLOTS - 1; s >= 0; s--) begin
				if (model_id[i] != '0 && node_kids[s] == model_id[i]) slot = s;
			end
			if (slot >= 0) begin
				exp_children[slot] = model_table[i];
				count++; // Scan stops once six are held.
			end
		end
	endfunction

	task automatic check_value(input string what, input node_record_t expected,
			input node_record_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_outputs(input node_id_t target);
		compute_expected(target);
		check_value("found", node_record_t'(exp_found), node_record_t'(found));
		check_value("node", exp_node, node_record);
		for (int s = 0; s < CHILD_SLOTS; s++) begin
			check_value($sformatf("child %0d", s), exp_children[s], child_records[s]);
		end
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0) $display("%s: ok", test_name);
		else $display("%s: %0d errors", test_name, test_errors);
		test_errors = 0;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_reset_state();
		test_name = "reset state";
		check_value("done", '0, node_record_t'(done));
		check_value("found", '0, node_record_t'(found));
		finish_test();
	endtask

	task automatic test_all_children();
		test_name = "all children";
		clear_table();
		place_node(20, 16'd50, {16'd16, 16'd15, 16'd14, 16'd13, 16'd12, 16'd11}, 16'h1234);
		place_node(3, 16'd11, '0, 16'h0100);
		place_node(40, 16'd12, '0, 16'h0200);
		place_node(7, 16'd13, '0, 16'h0300);
		place_node(90, 16'd14, '0, 16'h0400);
		place_node(55, 16'd15, '0, 16'h0500);
		place_node(99, 16'd16, '0, 16'h0600); // Sixth child sits on the last entry.
		place_node(60, 16'd17, '0, 16'h0700);
		// Package accessors agree with the record layout.
		check_value("id accessor", node_record_t'(16'd50),
			node_record_t'(record_node_id(model_table[20])));
		check_value("child accessor", node_record_t'(16'd14),
			node_record_t'(record_child_id(model_table[20], 3)));
		run_search(16'd50);
		check_outputs(16'd50);
		finish_test();
	endtask

	task automatic test_missing_children();
		test_name = "missing children";
		clear_table();
		place_node(0, 16'd60, {16'd24, 16'd23, 16'd0, 16'd22, 16'd0, 16'd21}, 16'h2222);
		place_node(50, 16'd21, '0, 16'h0011);
		place_node(12, 16'd22, '0, 16'h0022);
		place_node(81, 16'd24, '0, 16'h0044); // Id 23 is absent.
		run_search(16'd60);
		check_outputs(16'd60);
		finish_test();
	endtask

	task automatic test_missing_target();
		test_name = "missing target";
		clear_table();
		place_node(5, 16'd31, {16'd0, 16'd0, 16'd0, 16'd0, 16'd33, 16'd32}, 16'h3333);
		place_node(6, 16'd32, '0, 16'h0032);
		place_node(7, 16'd33, '0, 16'h0033);
		run_search(16'd555);
		check_outputs(16'd555);
		finish_test();
	endtask

	task automatic test_random_graph(input int round);
		logic [1023:0] used;
		node_id_t ids [MAX_NODES];
		id_list_t kids;
		node_id_t target;
		int count;
		int pick;
		test_name = $sformatf("random graph %0d", round);
		clear_table();
		used = '0;
		count = 20 + random_below(70);
		for (int i = 0; i < count; i++) begin
			do begin
				ids[i] = node_id_t'(1 + random_below(700)); // Unique, nonzero.
			end while (used[ids[i]]);
			used[ids[i]] = 1'b1;
		end
		for (int i = 0; i < count; i++) begin
			for (int s = 0; s < CHILD_SLOTS; s++) begin
				pick = random_below(4);
				if (pick == 0) kids[s] = '0;
				else if (pick == 1) kids[s] = node_id_t'(701 + random_below(90)); // Unused id.
				else kids[s] = ids[random_below(count)];
			end
			place_node((i * 37 + round) % MAX_NODES, ids[i], kids, field_t'(next_random()));
		end
		target = ids[random_below(count)];
		run_search(target);
		check_outputs(target);
		finish_test();
	endtask

	task automatic test_rewrite_node();
		test_name = "rewrite node";
		clear_table();
		place_node(30, 16'd70, {16'd76, 16'd75, 16'd74, 16'd73, 16'd72, 16'd71}, 16'h7070);
		for (int i = 0; i < CHILD_SLOTS; i++) begin
			place_node(31 + i, node_id_t'(71 + i), '0, field_t'(i));
			place_node(5 + 10 * i, node_id_t'(81 + i), '0, field_t'(16 + i));
		end
		place_node(80, 16'd71, '0, 16'h00ee); // Late second id 71, past the early stop.
		run_search(16'd70);
		check_outputs(16'd70);
		place_node(30, 16'd70, {16'd84, 16'd99, 16'd71, 16'd82, 16'd0, 16'd81}, 16'h7171);
		run_search(16'd70);
		check_outputs(16'd70);
		run_search(16'd70); // Same target again.
		check_outputs(16'd70);
		finish_test();
	endtask

	// ========================================
	// Sequence and watchdog
	// ========================================

	initial begin
		reset = 1'b1;
		find_node = 1'b0;
		target_id = '0;
		write_enable = 1'b0;
		write_address = '0;
		write_data = '0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		checks = 0;
		rng_state = 32'd3320;
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		test_reset_state();
		test_all_children();
		test_missing_children();
		test_missing_target();
		for (int r = 0; r < 3; r++) begin
			test_random_graph(r);
		end
		test_rewrite_node();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: searches did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// File: logic/node_search_top.sv
module node_search_top #(
	parameter int MAX_NODES = 100
) (
	input logic clk,
	input logic reset,
	input logic find_node,
	input node_record_pkg::node_id_t target_id,
	input logic write_enable,
	input node_record_pkg::node_addr_t write_address,
	input node_record_pkg::node_record_t write_data,
	output node_record_pkg::node_record_t node_record,
	output node_record_pkg::node_record_t [node_search_pkg::CHILD_SLOTS-1:0] child_records,
	output logic found,
	output logic done
);

	import node_record_pkg::*;

	// ========================================
	// Internal nets
	// ========================================

	node_addr_t read_address;   // Scan pointer into the table.
	node_record_t read_data;    // Entry under test.
	logic last_entry;
	logic clear_address;
	logic step_address;
	logic start_search;
	logic load_node;
	logic check_child;
	logic target_hit;
	logic children_full;

	// Node table.
	node_table_mem #(
		.MAX_NODES(MAX_NODES)
	) u_table (
		.clk(clk),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_address(read_address),
		.read_data(read_data)
	);

	// Scan address.
	scan_address_counter #(
		.MAX_NODES(MAX_NODES)
	) u_counter (
		.clk(clk),
		.reset(reset),
		.clear_address(clear_address),
		.step_address(step_address),
		.read_address(read_address),
		.last_entry(last_entry)
	);

	// Sequencing.
	node_search_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.find_node(find_node),
		.target_hit(target_hit),
		.children_full(children_full),
		.last_entry(last_entry),
		.start_search(start_search),
		.clear_address(clear_address),
		.step_address(step_address),
		.load_node(load_node),
		.check_child(check_child),
		.done(done)
	);

	// Compare and hold results.
	child_slot_bank u_bank (
		.clk(clk),
		.reset(reset),
		.find_node(find_node),
		.target_id(target_id),
		.read_data(read_data),
		.start_search(start_search),
		.load_node(load_node),
		.check_child(check_child),
		.target_hit(target_hit),
		.children_full(children_full),
		.node_record(node_record),
		.child_records(child_records),
		.found(found)
	);

endmodule

// File: logic/child_slot_bank.sv
module child_slot_bank (
	input logic clk,
	input logic reset,
	input logic find_node,
	input node_record_pkg::node_id_t target_id,
	input node_record_pkg::node_record_t read_data,
	input logic start_search,
	input logic load_node,
	input logic check_child,
	output logic target_hit,
	output logic children_full,
	output node_record_pkg::node_record_t node_record,
	output node_record_pkg::node_record_t [node_search_pkg::CHILD_SLOTS-1:0] child_records,
	output logic found
);

	import node_record_pkg::*;
	import node_search_pkg::*;

	node_id_t target;                  // Id being searched for.
	node_id_t entry_id;                // Id of the entry on the read port.
	child_count_t child_count;         // Slots filled so far.
	logic [CHILD_SLOTS-1:0] slot_match; // Entry id equals the slot's child id.
	logic [CHILD_SLOTS-1:0] slot_pick;  // Lowest matching slot, one-hot.

	// ========================================
	// Compare
	// ========================================

	assign entry_id = record_node_id(read_data);
	assign target_hit = (entry_id == target);
	assign children_full = (child_count == child_count_t'(CHILD_SLOTS));

	// Empty entries (id 0) never match a child.
	always_comb begin
		for (int s = 0; s < CHILD_SLOTS; s++) begin
			slot_match[s] = (entry_id != '0) && (record_child_id(node_record, s) == entry_id);
		end
	end

	assign slot_pick = slot_match & ~(slot_match - 1'b1); // Isolate the lowest set bit.

	// ========================================
	// Results
	// ========================================

	always_ff @(posedge clk) begin
		if (start_search) begin
			target <= target_id; // Latched with the accepted request.
		end
	end

	// Sentinel until something real is found.
	always_ff @(posedge clk) begin
		if (start_search) begin
			node_record <= REMOVED_NODE;
			child_records <= {CHILD_SLOTS{REMOVED_NODE}};
		end else if (load_node) begin
			node_record <= read_data;
		end else if (check_child) begin
			for (int s = 0; s < CHILD_SLOTS; s++) begin
				if (slot_pick[s]) begin
					child_records[s] <= read_data; // Slot order follows the node's child list.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			found <= 1'b0;
			child_count <= '0;
		end else if (start_search) begin
			found <= 1'b0;
			child_count <= '0;
		end else begin
			if (load_node) begin
				found <= 1'b1;
			end
			if (check_child && (slot_match != '0)) begin
				child_count <= child_count + 1'b1;
			end
		end
	end

	// A search only starts from an outside request.
	start_on_request: assert property (
		@(posedge clk) disable iff (reset) start_search |-> find_node
	) else $error("search started without find_node");

endmodule

// File: logic/node_search_fsm.sv
module node_search_fsm (
	input logic clk,
	input logic reset,
	input logic find_node,
	input logic target_hit,
	input logic children_full,
	input logic last_entry,
	output logic start_search,
	output logic clear_address,
	output logic step_address,
	output logic load_node,
	output logic check_child,
	output logic done
);

	import node_search_pkg::*;

	search_state_t state;
	search_state_t next_state;

	// ========================================
	// State register
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// ========================================
	// Next state
	// ========================================

	always_comb begin
		next_state = state; // Hold by default.
		case (state)
			IDLE: begin
				if (find_node) begin
					next_state = FIND_NODE; // Request only seen here.
				end
			end
			FIND_NODE:        next_state = WAIT_READ_NODE;
			WAIT_READ_NODE:   next_state = READ_NODE; // RAM read in flight.
			READ_NODE: begin
				// Stop on a hit, or give up at the end of the table.
				if (target_hit || last_entry) begin
					next_state = FIND_CHILDREN;
				end else begin
					next_state = SET_NODE_ADDRESS;
				end
			end
			SET_NODE_ADDRESS: next_state = WAIT_READ_NODE;
			FIND_CHILDREN:    next_state = WAIT_READ_CHILD;
			WAIT_READ_CHILD:  next_state = READ_CHILD;
			READ_CHILD: begin
				// Early exit once all six slots are held.
				if (children_full || last_entry) begin
					next_state = DONE;
				end else begin
					next_state = SET_CHILD_ADDRESS;
				end
			end
			SET_CHILD_ADDRESS: next_state = WAIT_READ_CHILD;
			DONE:              next_state = IDLE;
			default:           next_state = IDLE;
		endcase
	end

	// ========================================
	// Strobes
	// ========================================

	assign start_search = (state == IDLE) && find_node; // Accepted request.
	assign clear_address = (state == FIND_NODE) || (state == FIND_CHILDREN);
	assign step_address = (state == SET_NODE_ADDRESS) || (state == SET_CHILD_ADDRESS);
	assign load_node = (state == READ_NODE) && target_hit;       // Capture the match.
	assign check_child = (state == READ_CHILD) && !children_full; // Slots still open.

	// Completion pulse, one cycle after DONE.
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= (state == DONE);
		end
	end

	// Each search reports completion exactly once.
	done_single_pulse: assert property (
		@(posedge clk) disable iff (reset) done |=> !done
	) else $error("done held for more than one cycle");

endmodule

// File: logic/scan_address_counter.sv
module scan_address_counter #(
	parameter int MAX_NODES = 100
) (
	input logic clk,
	input logic reset,
	input logic clear_address,
	input logic step_address,
	output node_record_pkg::node_addr_t read_address,
	output logic last_entry
);

	import node_record_pkg::*;

	// Final entry of the scan.
	localparam node_addr_t LAST_ADDRESS = node_addr_t'(MAX_NODES - 1);

	// ========================================
	// Scan pointer
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			read_address <= '0;
		end else if (clear_address) begin
			read_address <= '0; // Restart at entry 0 for each scan.
		end else if (step_address) begin
			read_address <= read_address + 1'b1; // Next entry.
		end
	end

	assign last_entry = (read_address == LAST_ADDRESS); // Scan has reached the end.

	// The FSM must leave the scan at the last entry, never step past it.
	no_step_past_end: assert property (
		@(posedge clk) disable iff (reset) step_address |-> !last_entry
	) else $error("scan stepped past the last table entry");

endmodule

// File: logic/node_table_mem.sv
module node_table_mem #(
	parameter int MAX_NODES = 100
) (
	input logic clk,
	input logic write_enable,
	input node_record_pkg::node_addr_t write_address,
	input node_record_pkg::node_record_t write_data,
	input node_record_pkg::node_addr_t read_address,
	output node_record_pkg::node_record_t read_data
);

	import node_record_pkg::*;

	// ========================================
	// Storage
	// ========================================

	node_record_t table_ram [MAX_NODES]; // One record per entry.

	// Every entry starts empty, with id 0.
	initial begin
		for (int i = 0; i < MAX_NODES; i++) begin
			table_ram[i] = '0;
		end
	end

	// ========================================
	// Ports
	// ========================================

	// Single write port, registered read.
	// A read of the entry being written returns the old record.
	always_ff @(posedge clk) begin
		if (write_enable) begin
			table_ram[write_address] <= write_data; // Load from the top level.
		end
		read_data <= table_ram[read_address]; // Valid one cycle after the address.
	end

	// Loads from outside must stay inside the table.
	write_in_range: assert property (
		@(posedge clk) write_enable |-> (int'(write_address) < MAX_NODES)
	) else $error("table write beyond MAX_NODES");

endmodule

// File: logic/node_search_pkg.sv
package node_search_pkg;

	// ========================================
	// Child slots and sentinel
	// ========================================

	localparam int CHILD_SLOTS = 6;   // Children per node.
	typedef logic [2:0] child_count_t; // Counts 0 to 6.

	// Marks a removed or missing node.
	localparam node_record_pkg::node_id_t REMOVED_NODE_ID = 16'd800;

	// x and y zero, id, parent and cost at the sentinel, child pairs all zero.
	localparam node_record_pkg::node_record_t REMOVED_NODE = {
		32'd0,
		REMOVED_NODE_ID,
		REMOVED_NODE_ID,
		REMOVED_NODE_ID,
		192'd0
	};

	// Search sequence, three cycles per table entry.
	typedef enum logic [3:0] {
		IDLE              = 4'd0,
		FIND_NODE         = 4'd1,
		WAIT_READ_NODE    = 4'd2,
		READ_NODE         = 4'd3,
		SET_NODE_ADDRESS  = 4'd4,
		FIND_CHILDREN     = 4'd5,
		WAIT_READ_CHILD   = 4'd6,
		READ_CHILD        = 4'd7,
		SET_CHILD_ADDRESS = 4'd8,
		DONE              = 4'd9
	} search_state_t;

endpackage

// File: logic/node_record_pkg.sv
package node_record_pkg;

	// ========================================
	// Record geometry
	// ========================================

	localparam int FIELD_WIDTH = 16;                          // Bits in one field.
	localparam int FIELD_COUNT = 17;                          // Fields in one record.
	localparam int RECORD_WIDTH = FIELD_WIDTH * FIELD_COUNT; // 272 bits per record.

	typedef logic [FIELD_WIDTH-1:0] field_t;    // Raw field.
	typedef logic [FIELD_WIDTH-1:0] node_id_t;  // Node identifier.
	typedef logic [FIELD_WIDTH-1:0] cost_t;     // Path cost or edge distance.
	typedef logic [FIELD_WIDTH-1:0] coord_t;    // Grid x or y.

	typedef logic [RECORD_WIDTH-1:0] node_record_t; // Whole node, field 0 on top.
	typedef logic [6:0] node_addr_t;                // Table address, up to 128 entries.

	// ========================================
	// Field positions
	// ========================================

	// Counted from the top of the record downwards.
	localparam int FIELD_X = 0;
	localparam int FIELD_Y = 1;
	localparam int FIELD_ID = 2;
	localparam int FIELD_PARENT = 3;
	localparam int FIELD_COST = 4;
	localparam int FIELD_CHILD_BASE = 5; // Child id of slot 0, its distance follows.

	// Any field by index.
	function automatic field_t record_field(input node_record_t rec, input int index);
		return rec[(RECORD_WIDTH - 1 - FIELD_WIDTH * index) -: FIELD_WIDTH];
	endfunction

	// Id of the node itself.
	function automatic node_id_t record_node_id(input node_record_t rec);
		return node_id_t'(record_field(rec, FIELD_ID));
	endfunction

	// Child id held in slot 0 to 5.
	function automatic node_id_t record_child_id(input node_record_t rec, input int slot);
		return node_id_t'(record_field(rec, FIELD_CHILD_BASE + 2 * slot));
	endfunction

endpackage
